/* stim_pkg.sv */
`default_nettype none

package stim_pkg;

   // ######################################################################
   // widths
   // ######################################################################

   localparam int packet_w   = 32;               // one stimulus packet
   localparam int ctrl_w     = 8;                // bit 0 entry valid, 7:1 delay
   localparam int depth      = 64;               // entries in the memory
   localparam int addr_w     = $clog2(depth);    // memory pointer width
   localparam int cfg_addr_w = 2;                // four host registers
   localparam int cfg_data_w = 16;               // host data bus

   // ######################################################################
   // vector types
   // ######################################################################

   typedef logic [packet_w-1:0]        packet_t;
   typedef logic [ctrl_w-1:0]          ctrl_t;
   typedef logic [packet_w+ctrl_w-1:0] entry_t;  // packet above ctrl byte
   typedef logic [addr_w-1:0]          addr_t;
   typedef logic [ctrl_w-2:0]          delay_t;  // idle cycles after a packet
   typedef logic [cfg_data_w-1:0]      count_t;  // loaded / sent counters

   // replay states
   typedef enum logic [2:0]
   {
      seq_idle   = 3'd0,  // waiting for go
      seq_fetch  = 3'd1,  // read issued to memory
      seq_active = 3'd2,  // entry on the read port, packet offered
      seq_pause  = 3'd3,  // idle gap after a transfer
      seq_done   = 3'd4   // end marker seen, wait for go low
   } seq_state_t;

endpackage

`default_nettype wire

/* stim_cfg_regs.sv */
`default_nettype none

module stim_cfg_regs
(
   input  wire logic                                dut_clk,
   input  wire logic                                nreset,
   // host port
   input  wire logic                                cfg_write,
   input  wire logic [stim_pkg::cfg_addr_w-1:0]     cfg_addr,
   input  wire logic [stim_pkg::cfg_data_w-1:0]     cfg_wdata,
   output logic      [stim_pkg::cfg_data_w-1:0]     cfg_rdata,
   // control levels
   output logic                                     load,
   output logic                                     go,
   // status from loader and sequencer
   input  wire stim_pkg::count_t                    loaded_count,
   input  wire stim_pkg::count_t                    sent_count,
   input  wire logic                                full,
   input  wire logic                                done,
   input  wire logic                                busy
);

   // ######################################################################
   // control register, address 0
   // ######################################################################

   // only address 0 takes writes, the rest are status
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         load <= 1'b0;
         go   <= 1'b0;
      end
      else if (cfg_write && (cfg_addr == 2'd0))
      begin
         load <= cfg_wdata[0];  // bit 0 load
         go   <= cfg_wdata[1];  // bit 1 go
      end
   end

   // ######################################################################
   // read mux, zero latency
   // ######################################################################

   always_comb
   begin
      cfg_rdata = '0;
      case (cfg_addr)
         2'd0:
         begin
            cfg_rdata[0] = load;
            cfg_rdata[1] = go;
         end
         2'd1:
         begin
            // status bits
            cfg_rdata[0] = done;
            cfg_rdata[1] = full;
            cfg_rdata[2] = busy;
         end
         2'd2:    cfg_rdata = loaded_count;  // entries written
         2'd3:    cfg_rdata = sent_count;    // packets transferred
         default: cfg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* stim_loader.sv */
`default_nettype none

module stim_loader
(
   input  wire logic                 dut_clk,
   input  wire logic                 nreset,
   input  wire logic                 load,
   input  wire logic                 ext_valid,
   input  wire stim_pkg::entry_t     ext_entry,
   output logic                      mem_wr_en,
   output stim_pkg::addr_t           mem_wr_addr,
   output stim_pkg::entry_t          mem_wr_data,
   output stim_pkg::count_t          loaded_count,
   output logic                      full
);

   logic             load_q;     // load, one cycle late
   logic             load_rise;
   stim_pkg::addr_t  wr_ptr;
   stim_pkg::addr_t  ptr_base;   // pointer after rewind
   stim_pkg::count_t cnt_base;
   logic             full_base;

   assign load_rise = load & ~load_q;

   // a new load session starts from address 0 in the same cycle
   assign ptr_base  = load_rise ? '0 : wr_ptr;
   assign cnt_base  = load_rise ? '0 : loaded_count;
   assign full_base = load_rise ? 1'b0 : full;

   assign full        = (loaded_count == stim_pkg::count_t'(stim_pkg::depth));
   assign mem_wr_en   = load & ext_valid & ~full_base;  // drop when full
   assign mem_wr_addr = ptr_base;
   assign mem_wr_data = ext_entry;

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         load_q       <= 1'b0;
         wr_ptr       <= '0;
         loaded_count <= '0;
      end
      else
      begin
         load_q       <= load;
         wr_ptr       <= ptr_base + mem_wr_en;  // wraps at depth, full blocks it
         loaded_count <= cnt_base + mem_wr_en;
      end
   end

endmodule

`default_nettype wire

/* stim_mem.sv */
`default_nettype none

module stim_mem
(
   input  wire logic                 dut_clk,
   // write port, from loader
   input  wire logic                 wr_en,
   input  wire stim_pkg::addr_t      wr_addr,
   input  wire stim_pkg::entry_t     wr_data,
   // read port, from sequencer
   input  wire logic                 rd_en,
   input  wire stim_pkg::addr_t      rd_addr,
   output stim_pkg::entry_t          rd_data
);

   stim_pkg::entry_t ram [0:stim_pkg::depth-1];

   always_ff @(posedge dut_clk)
   begin
      if (wr_en)
         ram[wr_addr] <= wr_data;
   end

   // read register holds between fetches, so the packet stays put
   always_ff @(posedge dut_clk)
   begin
      if (rd_en)
         rd_data <= ram[rd_addr];
   end

endmodule

`default_nettype wire

/* stim_sequencer.sv */
`default_nettype none

module stim_sequencer
(
   input  wire logic                 dut_clk,
   input  wire logic                 nreset,
   input  wire logic                 go,         // may come in async
   input  wire logic                 dut_ready,
   // memory read port
   output logic                      mem_rd_en,
   output stim_pkg::addr_t           mem_rd_addr,
   input  wire stim_pkg::entry_t     mem_rd_data,
   // to the DUT
   output logic                      stim_valid,
   output stim_pkg::packet_t         stim_packet,
   output logic                      stim_done,
   // status
   output logic                      busy,
   output stim_pkg::count_t          sent_count
);

   logic                 go_meta;
   logic                 go_sync;
   stim_pkg::seq_state_t state;
   stim_pkg::seq_state_t state_nxt;
   stim_pkg::addr_t      rd_ptr;
   stim_pkg::delay_t     delay_cnt;   // remaining idle cycles
   stim_pkg::ctrl_t      entry_ctrl;
   stim_pkg::delay_t     entry_delay;
   logic                 entry_valid;
   logic                 xfer;        // packet taken by DUT
   logic                 last_entry;  // pointer at top of memory

   // ######################################################################
   // go synchronizer
   // ######################################################################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         go_meta <= 1'b0;
         go_sync <= 1'b0;
      end
      else
      begin
         go_meta <= go;
         go_sync <= go_meta;
      end
   end

   // ######################################################################
   // entry decode and outputs
   // ######################################################################

   assign entry_ctrl  = mem_rd_data[stim_pkg::ctrl_w-1:0];
   assign entry_valid = entry_ctrl[0];
   assign entry_delay = entry_ctrl[stim_pkg::ctrl_w-1:1];
   assign stim_packet = mem_rd_data[stim_pkg::ctrl_w +: stim_pkg::packet_w];

   assign stim_valid  = (state == stim_pkg::seq_active) & entry_valid;
   assign xfer        = stim_valid & dut_ready;
   assign last_entry  = (rd_ptr == stim_pkg::addr_t'(stim_pkg::depth - 1));

   assign mem_rd_en   = (state == stim_pkg::seq_fetch);  // one read per entry
   assign mem_rd_addr = rd_ptr;
   assign stim_done   = (state == stim_pkg::seq_done);
   assign busy        = (state != stim_pkg::seq_idle) & (state != stim_pkg::seq_done);

   // ######################################################################
   // replay FSM
   // ######################################################################

   always_comb
   begin
      state_nxt = state;
      if (!go_sync)
         state_nxt = stim_pkg::seq_idle;  // go low rewinds from anywhere
      else
      begin
         case (state)
            stim_pkg::seq_idle:  state_nxt = stim_pkg::seq_fetch;
            stim_pkg::seq_fetch: state_nxt = stim_pkg::seq_active;  // data next cycle
            stim_pkg::seq_active:
            begin
               if (!entry_valid)
                  state_nxt = stim_pkg::seq_done;  // end marker
               else if (xfer)
               begin
                  if (last_entry)
                     state_nxt = stim_pkg::seq_done;  // ran off the memory
                  else if (entry_delay != '0)
                     state_nxt = stim_pkg::seq_pause;
                  else
                     state_nxt = stim_pkg::seq_fetch;
               end
            end
            stim_pkg::seq_pause:
            begin
               if (delay_cnt <= stim_pkg::delay_t'(1))
                  state_nxt = stim_pkg::seq_fetch;  // last idle cycle
            end
            stim_pkg::seq_done:  state_nxt = stim_pkg::seq_done;
            default:             state_nxt = stim_pkg::seq_idle;
         endcase
      end
   end

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state      <= stim_pkg::seq_idle;
         rd_ptr     <= '0;
         delay_cnt  <= '0;
         sent_count <= '0;
      end
      else
      begin
         state <= state_nxt;

         // pointer back to 0 whenever go drops
         if (!go_sync)
            rd_ptr <= '0;
         else if (xfer)
            rd_ptr <= rd_ptr + 1'b1;

         if (xfer)
            delay_cnt <= entry_delay;  // gap owed after this packet
         else if (state == stim_pkg::seq_pause)
            delay_cnt <= delay_cnt - 1'b1;

         // kept across rewinds
         if (xfer)
            sent_count <= sent_count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* stim_player_top.sv */
`default_nettype none

module stim_player_top
(
   input  wire logic                                dut_clk,
   input  wire logic                                nreset,
   // host register port
   input  wire logic                                cfg_write,
   input  wire logic [stim_pkg::cfg_addr_w-1:0]     cfg_addr,
   input  wire logic [stim_pkg::cfg_data_w-1:0]     cfg_wdata,
   output logic      [stim_pkg::cfg_data_w-1:0]     cfg_rdata,
   // entry load stream
   input  wire logic                                ext_valid,
   input  wire stim_pkg::entry_t                    ext_entry,
   // DUT side
   input  wire logic                                dut_ready,
   output logic                                     stim_valid,
   output stim_pkg::packet_t                        stim_packet,
   output logic                                     stim_done
);

   logic             load;
   logic             go;
   logic             full;
   logic             busy;
   stim_pkg::count_t loaded_count;
   stim_pkg::count_t sent_count;

   // write side
   logic             mem_wr_en;
   stim_pkg::addr_t  mem_wr_addr;
   stim_pkg::entry_t mem_wr_data;

   // read side
   logic             mem_rd_en;
   stim_pkg::addr_t  mem_rd_addr;
   stim_pkg::entry_t mem_rd_data;

   // ######################################################################
   // host registers
   // ######################################################################

   stim_cfg_regs u_regs
   (
      .dut_clk      (dut_clk),
      .nreset       (nreset),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .load         (load),
      .go           (go),
      .loaded_count (loaded_count),
      .sent_count   (sent_count),
      .full         (full),
      .done         (stim_done),
      .busy         (busy)
   );

   // ######################################################################
   // load path and memory
   // ######################################################################

   stim_loader u_loader
   (
      .dut_clk      (dut_clk),
      .nreset       (nreset),
      .load         (load),
      .ext_valid    (ext_valid),
      .ext_entry    (ext_entry),
      .mem_wr_en    (mem_wr_en),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .loaded_count (loaded_count),
      .full         (full)
   );

   stim_mem u_mem
   (
      .dut_clk (dut_clk),
      .wr_en   (mem_wr_en),
      .wr_addr (mem_wr_addr),
      .wr_data (mem_wr_data),
      .rd_en   (mem_rd_en),
      .rd_addr (mem_rd_addr),
      .rd_data (mem_rd_data)
   );

   // replay side
   stim_sequencer u_seq
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .go          (go),
      .dut_ready   (dut_ready),
      .mem_rd_en   (mem_rd_en),
      .mem_rd_addr (mem_rd_addr),
      .mem_rd_data (mem_rd_data),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done),
      .busy        (busy),
      .sent_count  (sent_count)
   );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
   output logic dut_clk,
   output logic nreset
);

   // free running, period 10
   initial
   begin
      dut_clk = 1'b0;
      forever
         #5 dut_clk = ~dut_clk;  // half period
   end

   // reset held for 4 rising edges
   initial
   begin
      nreset = 1'b0;
      repeat (4) @(posedge dut_clk);
      nreset <= 1'b1;
   end

endmodule

`default_nettype wire

/* stim_player_props.sv */
`default_nettype none

module stim_player_props
(
   input wire logic                 dut_clk,
   input wire logic                 nreset,
   input wire logic                 dut_ready,
   input wire logic                 stim_valid,
   input wire logic                 stim_done,
   input wire stim_pkg::packet_t    stim_packet,
   input wire stim_pkg::seq_state_t state
);

   // ######################################################################
   // handshake rules
   // ######################################################################

   // offered packet stays put until the DUT takes it
   hold_under_backpressure: assert property (@(posedge dut_clk) disable iff (!nreset)
      (stim_valid && !dut_ready) |=> (stim_valid && $stable(stim_packet)))
      else $error("stim_valid dropped or stim_packet moved while dut_ready was low");

   done_excludes_valid: assert property (@(posedge dut_clk) disable iff (!nreset)
      !(stim_done && stim_valid))
      else $error("stim_done and stim_valid high in the same cycle");

   // FSM encoding
   state_in_range: assert property (@(posedge dut_clk) disable iff (!nreset)
      state inside {stim_pkg::seq_idle, stim_pkg::seq_fetch, stim_pkg::seq_active,
                    stim_pkg::seq_pause, stim_pkg::seq_done})
      else $error("sequencer state outside the defined states");

endmodule

bind stim_sequencer stim_player_props props_i
(
   .dut_clk     (dut_clk),
   .nreset      (nreset),
   .dut_ready   (dut_ready),
   .stim_valid  (stim_valid),
   .stim_done   (stim_done),
   .stim_packet (stim_packet),
   .state       (state)
);

`default_nettype wire

/* tb_stim_player.sv */
`default_nettype none

module tb_stim_player;

   logic                                dut_clk;
   logic                                nreset;
   logic                                cfg_write;
   logic [stim_pkg::cfg_addr_w-1:0]     cfg_addr;
   logic [stim_pkg::cfg_data_w-1:0]     cfg_wdata;
   logic [stim_pkg::cfg_data_w-1:0]     cfg_rdata;
   logic                                ext_valid;
   stim_pkg::entry_t                    ext_entry;
   logic                                dut_ready;
   logic                                stim_valid;
   stim_pkg::packet_t                   stim_packet;
   logic                                stim_done;

   // trace contents
   stim_pkg::packet_t load_pkt  [0:stim_pkg::depth-1];
   stim_pkg::ctrl_t   load_ctrl [0:stim_pkg::depth-1];
   stim_pkg::packet_t exp_pkt   [0:stim_pkg::depth-1];
   int                exp_dly   [0:stim_pkg::depth-1];
   int                n_load;
   int                n_exp;
   int                exp_loaded;
   int                exp_sent;

   int                mismatch_count;
   int                fault_count;    // timeouts, file trouble
   logic [31:0]       rng_state;
   logic [stim_pkg::cfg_data_w-1:0] rd;

   tb_clock_gen clk_gen_i
   (
      .dut_clk (dut_clk),
      .nreset  (nreset)
   );

   stim_player_top stim_player_top_i
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .cfg_rdata   (cfg_rdata),
      .ext_valid   (ext_valid),
      .ext_entry   (ext_entry),
      .dut_ready   (dut_ready),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done)
   );

   // ######################################################################
   // helpers
   // ######################################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      mismatch_count++;
   endtask

   task automatic next_ready;
      rng_state = xorshift32(rng_state);
      dut_ready <= (rng_state[1:0] != 2'b00);  // ready about 3 of 4 cycles
   endtask

   task automatic read_trace;
      int          fd;
      int          r;
      int          c;
      int          dly;
      int          vld;
      int          cnt_a;
      int          cnt_b;
      logic [7:0]  kind;
      logic [31:0] pkt;
      logic        at_end;
      fd = $fopen("stim_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open stim_trace.txt");
         fault_count++;
         return;
      end
      at_end = 1'b0;
      while (!at_end)
      begin
         r = $fscanf(fd, " %c", kind);  // record tag
         if (r != 1)
            at_end = 1'b1;
         else if (kind == "#")
         begin
            c = $fgetc(fd);
            while (c != 10 && c != -1)
               c = $fgetc(fd);  // rest of comment line
         end
         else if (kind == "L")
         begin
            r = $fscanf(fd, "%h %d %d", pkt, dly, vld);
            load_pkt[n_load]  = pkt;
            load_ctrl[n_load] = {stim_pkg::delay_t'(dly), vld[0]};
            n_load++;
         end
         else if (kind == "E")
         begin
            r = $fscanf(fd, "%h %d", pkt, dly);
            exp_pkt[n_exp] = pkt;
            exp_dly[n_exp] = dly;
            n_exp++;
         end
         else if (kind == "C")
         begin
            r = $fscanf(fd, "%d %d", cnt_a, cnt_b);
            exp_loaded = cnt_a;
            exp_sent   = cnt_b;
         end
      end
      $fclose(fd);
   endtask

   // register write, control in effect after the second edge
   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      @(posedge dut_clk);
      cfg_write <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      @(posedge dut_clk);
      cfg_write <= 1'b0;
   endtask

   task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
      @(posedge dut_clk);
      cfg_addr <= addr;
      @(negedge dut_clk);
      data = cfg_rdata;  // combinational read, settled mid cycle
   endtask

   task automatic wait_reset;
      int n;
      n = 0;
      while (nreset !== 1'b1 && n < 20)
      begin
         @(posedge dut_clk);
         n++;
      end
      if (nreset !== 1'b1)
      begin
         $display("reset was never released");
         fault_count++;
      end
   endtask

   // ######################################################################
   // load and replay
   // ######################################################################

   task automatic load_entries;
      write_reg(2'd0, 16'h0001);  // load on
      for (int i = 0; i < n_load; i++)
      begin
         @(posedge dut_clk);
         ext_valid <= 1'b1;
         ext_entry <= {load_pkt[i], load_ctrl[i]};
      end
      @(posedge dut_clk);
      ext_valid <= 1'b0;
      write_reg(2'd0, 16'h0000);
   endtask

   task automatic replay_stream(input int pass_no);
      int                n_sent;
      int                cycles;
      int                idle_run;  // valid-low cycles since last transfer
      int                owed;      // delay of the last transferred entry
      logic              held;
      logic              finished;
      stim_pkg::packet_t held_pkt;
      n_sent   = 0;
      cycles   = 0;
      idle_run = 0;
      owed     = 0;
      held     = 1'b0;
      finished = 1'b0;
      write_reg(2'd0, 16'h0002);  // go on
      while (!finished && cycles < 2000)
      begin
         @(negedge dut_clk);
         cycles++;
         if (held)
         begin
            if (!stim_valid || stim_packet !== held_pkt)
               report_mismatch("offered packet changed while dut_ready was low");
            held = 1'b0;
         end
         if (stim_done)
            finished = 1'b1;
         else if (stim_valid)
         begin
            if (idle_run < owed)
               report_mismatch($sformatf("only %0d idle cycles, delay %0d", idle_run, owed));
            if (dut_ready)
            begin
               // transfer at the coming edge
               if (n_sent >= n_exp)
                  report_mismatch($sformatf("packet %h after the end marker", stim_packet));
               else if (stim_packet !== exp_pkt[n_sent])
                  report_mismatch($sformatf("packet %0d is %h, expected %h",
                                            n_sent, stim_packet, exp_pkt[n_sent]));
               owed     = (n_sent < n_exp) ? exp_dly[n_sent] : 0;
               idle_run = 0;
               n_sent++;
            end
            else
            begin
               held     = 1'b1;  // back-pressure
               held_pkt = stim_packet;
            end
         end
         else
            idle_run++;
         @(posedge dut_clk);
         next_ready();
      end
      if (!finished)
      begin
         $display("timed out waiting for stim_done on pass %0d", pass_no);
         fault_count++;
      end
      if (n_sent != n_exp)
         report_mismatch($sformatf("pass %0d sent %0d packets, expected %0d",
                                   pass_no, n_sent, n_exp));
   endtask

   task automatic rewind;
      int n;
      write_reg(2'd0, 16'h0000);  // go low
      n = 0;
      while (stim_done && n < 20)
      begin
         @(negedge dut_clk);
         n++;
      end
      if (stim_done)
      begin
         $display("stim_done stayed high after go was cleared");
         fault_count++;
      end
   endtask

   task automatic overflow_load;
      write_reg(2'd0, 16'h0001);
      for (int i = 0; i < stim_pkg::depth + 3; i++)
      begin
         @(posedge dut_clk);
         ext_valid <= 1'b1;
         ext_entry <= {stim_pkg::packet_t'(i) ^ 32'h5a00_0000, 8'h01};  // index pattern
      end
      @(posedge dut_clk);
      ext_valid <= 1'b0;
   endtask

   // ######################################################################
   // main sequence
   // ######################################################################

   initial
   begin
      cfg_write      = 1'b0;
      cfg_addr       = '0;
      cfg_wdata      = '0;
      ext_valid      = 1'b0;
      ext_entry      = '0;
      dut_ready      = 1'b0;
      mismatch_count = 0;
      fault_count    = 0;
      rng_state      = 32'd5143;  // xorshift seed
      n_load         = 0;
      n_exp          = 0;
      exp_loaded     = 0;
      exp_sent       = 0;

      read_trace();
      wait_reset();

      load_entries();
      read_reg(2'd2, rd);
      if (rd != exp_loaded)
         report_mismatch($sformatf("loaded count %0d, expected %0d", rd, exp_loaded));
      read_reg(2'd1, rd);
      if (rd[1])
         report_mismatch("full set after a partial load");

      replay_stream(1);
      read_reg(2'd1, rd);
      if (!rd[0] || rd[2])
         report_mismatch($sformatf("status %b after replay, expected done and not busy", rd[2:0]));

      rewind();
      replay_stream(2);
      read_reg(2'd3, rd);
      if (rd != 2 * exp_sent)  // sent counter survives rewind
         report_mismatch($sformatf("sent count %0d, expected %0d", rd, 2 * exp_sent));

      overflow_load();
      read_reg(2'd2, rd);
      if (rd != stim_pkg::depth)
         report_mismatch($sformatf("loaded count %0d after overflow, expected %0d",
                                   rd, stim_pkg::depth));
      read_reg(2'd1, rd);
      if (!rd[1])
         report_mismatch("full not set after overflow");
      write_reg(2'd0, 16'h0000);

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
      if (mismatch_count == 0 && fault_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* stim_trace.txt */
# L packet_hex delay valid : entry to load, in memory order
# E packet_hex delay : expected transfer    C loaded sent : final counts
L 1a2b3c4d 0 1
L 00000001 2 1
L deadbeef 1 1
L 5a5a5a5a 0 1
L 0badf00d 3 1
L 7e7e0001 5 1
L 00000000 0 0
L ffffffff 0 1
E 1a2b3c4d 0
E 00000001 2
E deadbeef 1
E 5a5a5a5a 0
E 0badf00d 3
E 7e7e0001 5
C 8 6

/* flist.f */
stim_pkg.sv
stim_cfg_regs.sv
stim_loader.sv
stim_mem.sv
stim_sequencer.sv
stim_player_top.sv
tb_clock_gen.sv
stim_player_props.sv
tb_stim_player.sv
